// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f game2048.f --top-module game_tb -Mdir obj_dir
	./obj_dir/Vgame_tb > sim.log 2>&1; st=$$?; cat sim.log; test $$st -eq 0
	! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: game2048.f
+incdir+source
source/game_pkg.sv
source/line_merge.sv
source/board_shift.sv
source/tile_spawner.sv
source/game_ctrl.sv
source/game_top.sv
sim/game_chk.sv
sim/game_tb.sv

// File: sim/game_chk.sv
`timescale 1ns/100ps

module game_chk import game_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic restart,
	input logic [3:0] dir,
	input board_t board,
	input score_t score,
	input draw_state_t draw_state,
	input logic ready
);

	logic [2:0] low_cnt; // cycles with ready low.
	int fails = 0; // failed assertions so far.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			low_cnt <= 3'd0;
		else if (ready)
			low_cnt <= 3'd0;
		else if (low_cnt != 3'd7)
			low_cnt <= low_cnt + 3'd1;
	end

	a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
		low_cnt <= 3'd3)
		else begin
			$error("ready stayed low for more than three cycles");
			fails++;
		end

	// no moves once the game is decided.
	a_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		(draw_state != PLAYING && !restart) |=> $stable(board))
		else begin
			$error("board changed after the game ended");
			fails++;
		end

	a_score_up: assert property (@(posedge clk) disable iff (!rst_n)
		!restart |=> (score >= $past(score)))
		else begin
			$error("score decreased without restart");
			fails++;
		end

	a_multi_dir: assert property (@(posedge clk) disable iff (!rst_n)
		(ready && !restart && !$onehot0(dir)) |=> $stable(board))
		else begin
			$error("board changed on a multi-bit dir");
			fails++;
		end

endmodule

// File: sim/game_tb.sv
`timescale 1ns/100ps
`include "game_settings.svh"

module game_tb import game_pkg::*; ();

	localparam int RAND_MOVES = 60;
	localparam int WIN_MAX = 300;
	localparam int LOSS_MAX = 1500;
	localparam int TOTAL_MOVES = RAND_MOVES + 3 + WIN_MAX + 3 + LOSS_MAX + 2;
	localparam int CYCLE_LIMIT = TOTAL_MOVES * 8 + 200;

	logic clk;
	logic rst_n;
	logic restart;
	exp_t goal;
	logic [3:0] dir;
	board_t board;
	score_t score;
	draw_state_t draw_state;
	logic ready;

	// reference model.
	logic [3:0] m_board [16];
	score_t m_score;
	logic [15:0] m_lfsr;
	draw_state_t m_state;

	logic [31:0] rnd_state;
	int cycles;
	int checks;
	int errors;
	int test_errors;

	game_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.goal(goal),
		.dir(dir),
		.board(board),
		.score(score),
		.draw_state(draw_state),
		.ready(ready)
	);

	bind game_top game_chk u_chk (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.dir(dir),
		.board(board),
		.score(score),
		.draw_state(draw_state),
		.ready(ready)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ******************************
	// reference model
	function automatic logic [31:0] next_rand();
		rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
		return rnd_state;
	endfunction

	function automatic logic [3:0] random_dir();
		logic [31:0] r;
		r = next_rand();
		return 4'b0001 << r[17:16];
	endfunction

	// position p of line l, p = 0 at the target edge.
	function automatic logic [3:0] line_cell(input logic [3:0] d, input int l, input int p);
		case (d)
			DIR_UP: return 4'(p*4 + l);
			DIR_DOWN: return 4'((3-p)*4 + l);
			DIR_RIGHT: return 4'(l*4 + 3 - p);
			default: return 4'(l*4 + p);
		endcase
	endfunction

	function automatic board_t model_vec();
		board_t v;
		for (int i = 0; i < 16; i++)
			v[4*i +: 4] = m_board[i];
		return v;
	endfunction

	task automatic model_spawn();
		logic [3:0] c;
		logic found;
		found = 1'b0;
		for (int off = 0; off < 16; off++) begin
			c = m_lfsr[3:0] + 4'(off);
			if (!found && m_board[c] == 4'd0) begin
				found = 1'b1;
				m_board[c] = (m_lfsr[7:4] == 4'd0) ? 4'd2 : 4'd1;
			end
		end
		if (found)
			m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? `LFSR_TAPS : 16'h0000);
	endtask

	task automatic model_judge();
		logic full;
		logic pair;
		logic win;
		full = 1'b1;
		pair = 1'b0;
		win = 1'b0;
		for (int i = 0; i < 16; i++) begin
			if (m_board[i] >= goal) win = 1'b1;
			if (m_board[i] == 4'd0) full = 1'b0;
			if (i % 4 != 3 && m_board[i] == m_board[i+1]) pair = 1'b1;
			if (i < 12 && m_board[i] == m_board[i+4]) pair = 1'b1;
		end
		if (win)
			m_state = WON;
		else if (full && !pair)
			m_state = LOST;
		else
			m_state = PLAYING;
	endtask

	task automatic model_move(input logic [3:0] d);
		logic [3:0] idx [4];
		logic [3:0] outl [4];
		logic [3:0] vals [$];
		logic any;
		int k;
		any = 1'b0;
		if (m_state == PLAYING && $onehot(d)) begin
			for (int l = 0; l < 4; l++) begin
				vals.delete();
				for (int p = 0; p < 4; p++) begin
					idx[p] = line_cell(d, l, p);
					outl[p] = 4'd0;
					if (m_board[idx[p]] != 4'd0)
						vals.push_back(m_board[idx[p]]);
				end
				k = 0;
				while (vals.size() > 0) begin
					if (vals.size() > 1 && vals[0] == vals[1]) begin
						outl[k] = vals[0] + 4'd1;
						m_score = m_score + (16'd1 << outl[k]);
						void'(vals.pop_front());
						void'(vals.pop_front());
					end else begin
						outl[k] = vals.pop_front();
					end
					k++;
				end
				for (int p = 0; p < 4; p++) begin
					if (m_board[idx[p]] != outl[p]) any = 1'b1;
					m_board[idx[p]] = outl[p];
				end
			end
			if (any)
				model_spawn();
			model_judge();
		end
	endtask

	task automatic model_restart();
		for (int i = 0; i < 16; i++)
			m_board[i] = 4'd0;
		m_score = '0;
		m_state = PLAYING;
		model_spawn();
		model_spawn();
	endtask

	// ******************************
	// stimulus and checks
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready();
		while (!ready)
			tick();
	endtask

	task automatic check_outputs();
		board_t exp_board;
		exp_board = model_vec();
		checks++;
		if (board !== exp_board) begin
			$display("ERROR t=%0t board: got %h expected %h", $time, board, exp_board);
			test_errors++;
		end
		checks++;
		if (score !== m_score) begin
			$display("ERROR t=%0t score: got %0d expected %0d", $time, score, m_score);
			test_errors++;
		end
		checks++;
		if (draw_state !== m_state) begin
			$display("ERROR t=%0t draw_state: got %0d expected %0d", $time, draw_state, m_state);
			test_errors++;
		end
	endtask

	task automatic play_move(input logic [3:0] d, input int hold);
		wait_ready();
		dir = d;
		repeat (hold) tick();
		dir = 4'b0000;
		wait_ready();
		model_move(d);
		check_outputs();
	endtask

	task automatic pulse_restart();
		wait_ready();
		restart = 1'b1;
		tick();
		restart = 1'b0;
		model_restart();
		wait_ready();
		check_outputs();
	endtask

	task automatic report_test(input string name);
		$display("test %-8s done, %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		int n;
		clk = 1'b0;
		rst_n = 1'b0;
		restart = 1'b0;
		goal = 4'd11;
		dir = 4'b0000;
		rnd_state = 32'ha74b;
		cycles = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		m_lfsr = `LFSR_SEED;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		model_restart();
		wait_ready();
		check_outputs();
		report_test("start");

		for (int i = 0; i < RAND_MOVES; i++)
			play_move(random_dir(), 2);
		report_test("random");

		play_move(DIR_LEFT, 10); // held key, one move.
		play_move(4'b0101, 2);
		play_move(4'b1010, 2);
		report_test("ignored");

		pulse_restart();
		report_test("restart");

		goal = 4'd3;
		n = 0;
		while (m_state == PLAYING && n < WIN_MAX) begin
			play_move(random_dir(), 2);
			n++;
		end
		if (m_state != WON) begin
			$display("win test: model never reached exponent %0d in %0d moves", goal, n);
			test_errors++;
		end
		for (int i = 0; i < 3; i++)
			play_move(random_dir(), 2);
		report_test("win");

		goal = 4'd11;
		pulse_restart();
		n = 0;
		while (m_state == PLAYING && n < LOSS_MAX) begin
			play_move(random_dir(), 2);
			n++;
		end
		if (m_state != LOST) begin
			$display("loss test: game not lost within %0d moves", n);
			test_errors++;
		end
		report_test("loss");

		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			uut.u_chk.fails);
		if (errors == 0 && uut.u_chk.fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: source/board_shift.sv
`timescale 1ns/100ps
`include "game_settings.svh"

module board_shift import game_pkg::*; (
	input board_t cur_board,
	input dir_t move_dir,
	output board_t shifted_board,
	output score_t move_points,
	output logic moved
);

	localparam int N = `BOARD_N;
	localparam int EW = `EXP_W;

	line_t lines_in [N];
	line_t lines_out [N];
	score_t line_pts [N];
	logic line_chg [N];

	// board cell of position p in line l, index 0 is the target edge.
	function automatic int cell_of(input dir_t d, input int l, input int p);
		int idx;
		case (d)
			DIR_UP: idx = p*N + l;
			DIR_DOWN: idx = (N-1-p)*N + l;
			DIR_RIGHT: idx = l*N + (N-1-p);
			default: idx = l*N + p; // left.
		endcase
		return idx;
	endfunction

	// ******************************
	// gather
	always_comb begin
		for (int l = 0; l < N; l++) begin
			for (int p = 0; p < N; p++) begin
				lines_in[l][EW*p +: EW] = cur_board[EW*cell_of(move_dir, l, p) +: EW];
			end
		end
	end

	genvar g;
	generate
		for (g = 0; g < N; g++) begin : g_line
			line_merge u_merge (
				.line_in(lines_in[g]),
				.line_out(lines_out[g]),
				.points(line_pts[g]),
				.changed(line_chg[g])
			);
		end
	endgenerate

	// ******************************
	// scatter and totals
	always_comb begin
		shifted_board = '0;
		move_points = '0;
		moved = 1'b0;
		for (int l = 0; l < N; l++) begin
			for (int p = 0; p < N; p++) begin
				shifted_board[EW*cell_of(move_dir, l, p) +: EW] = lines_out[l][EW*p +: EW];
			end
			move_points = move_points + line_pts[l];
			moved = moved | line_chg[l];
		end
	end

endmodule

// File: source/game_ctrl.sv
`timescale 1ns/100ps
`include "game_settings.svh"

module game_ctrl import game_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic restart,
	input exp_t goal,
	input logic [3:0] dir,
	input board_t shifted_board,
	input score_t move_points,
	input logic moved,
	input cell_idx_t spawn_cell,
	input exp_t spawn_exp,
	input logic has_empty,
	output board_t cur_board,
	output dir_t move_dir,
	output logic spawn_step,
	output score_t score,
	output draw_state_t draw_state,
	output logic ready
);

	localparam int N = `BOARD_N;
	localparam int EW = `EXP_W;

	ctrl_state_t state;
	logic [3:0] dir_q;
	logic moved_q;
	logic accept;
	logic won;
	logic lost;

	assign ready = (state == ST_IDLE);

	// one move per press, one-hot only.
	assign accept = ready && (draw_state == PLAYING) && $onehot(dir) && (dir_q == 4'b0000);

	assign spawn_step = !restart && has_empty &&
		(state == ST_START1 || state == ST_START2 || (state == ST_SPAWN && moved_q));

	// ******************************
	// win / lose
	always_comb begin
		logic full;
		logic pair;
		full = 1'b1;
		pair = 1'b0;
		won = 1'b0;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				if (cur_board[EW*(r*N+c) +: EW] >= goal) won = 1'b1;
				if (cur_board[EW*(r*N+c) +: EW] == '0) full = 1'b0;
				if (c < N-1 && cur_board[EW*(r*N+c) +: EW] == cur_board[EW*(r*N+c+1) +: EW])
					pair = 1'b1; // horizontal neighbour.
				if (r < N-1 && cur_board[EW*(r*N+c) +: EW] == cur_board[EW*((r+1)*N+c) +: EW])
					pair = 1'b1; // vertical neighbour.
			end
		end
		lost = full && !pair;
	end

	// ******************************
	// fsm and board registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_START1;
			dir_q <= 4'b0000;
			moved_q <= 1'b0;
			move_dir <= DIR_UP;
			cur_board <= '0;
			score <= '0;
			draw_state <= PLAYING;
		end else begin
			dir_q <= dir;
			if (restart) begin
				state <= ST_START1;
				moved_q <= 1'b0;
				cur_board <= '0;
				score <= '0;
				draw_state <= PLAYING;
			end else begin
				case (state)
					ST_START1: state <= ST_START2;
					ST_START2: state <= ST_IDLE;
					ST_IDLE: begin
						if (accept) begin
							move_dir <= dir_t'(dir);
							state <= ST_SHIFT;
						end
					end
					ST_SHIFT: begin
						cur_board <= shifted_board;
						score <= score + move_points; // wraps.
						moved_q <= moved;
						state <= ST_SPAWN;
					end
					ST_SPAWN: state <= ST_CHECK;
					ST_CHECK: begin
						if (won)
							draw_state <= WON;
						else if (lost)
							draw_state <= LOST;
						else
							draw_state <= PLAYING;
						state <= ST_IDLE;
					end
					default: state <= ST_START1;
				endcase
				if (spawn_step)
					cur_board[EW*spawn_cell +: EW] <= spawn_exp; // new tile.
			end
		end
	end

endmodule

// File: source/game_pkg.sv
`include "game_settings.svh"

package game_pkg;

	typedef logic [`EXP_W-1:0] exp_t; // tile value is 2**exp.
	typedef logic [`BOARD_N*`EXP_W-1:0] line_t;
	typedef logic [`BOARD_N*`BOARD_N*`EXP_W-1:0] board_t; // cell r*4+c.
	typedef logic [$clog2(`BOARD_N*`BOARD_N)-1:0] cell_idx_t;
	typedef logic [`SCORE_W-1:0] score_t;

	typedef enum logic [3:0] {
		DIR_UP = 4'b0001,
		DIR_DOWN = 4'b0010,
		DIR_LEFT = 4'b0100,
		DIR_RIGHT = 4'b1000
	} dir_t;

	typedef enum logic [1:0] {PLAYING, WON, LOST} draw_state_t;

	typedef enum logic [2:0] {
		ST_START1,
		ST_START2,
		ST_IDLE,
		ST_SHIFT,
		ST_SPAWN,
		ST_CHECK
	} ctrl_state_t;

endpackage

// File: source/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// ******************************
// board geometry
`define BOARD_N 4
`define EXP_W 4

// ******************************
// score and random source
`define SCORE_W 16
`define LFSR_SEED 16'hACE1
`define LFSR_TAPS 16'hB400 // galois mask.

`endif

// File: source/game_top.sv
`timescale 1ns/100ps

module game_top import game_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic restart,
	input exp_t goal,
	input logic [3:0] dir,
	output board_t board,
	output score_t score,
	output draw_state_t draw_state,
	output logic ready
);

	board_t cur_board;
	board_t shifted_board;
	dir_t move_dir;
	score_t move_points;
	logic moved;
	logic spawn_step;
	cell_idx_t spawn_cell;
	exp_t spawn_exp;
	logic has_empty;

	assign board = cur_board;

	game_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.goal(goal),
		.dir(dir),
		.shifted_board(shifted_board),
		.move_points(move_points),
		.moved(moved),
		.spawn_cell(spawn_cell),
		.spawn_exp(spawn_exp),
		.has_empty(has_empty),
		.cur_board(cur_board),
		.move_dir(move_dir),
		.spawn_step(spawn_step),
		.score(score),
		.draw_state(draw_state),
		.ready(ready)
	);

	board_shift u_shift (
		.cur_board(cur_board),
		.move_dir(move_dir),
		.shifted_board(shifted_board),
		.move_points(move_points),
		.moved(moved)
	);

	tile_spawner u_spawn (
		.clk(clk),
		.rst_n(rst_n),
		.cur_board(cur_board),
		.spawn_step(spawn_step),
		.spawn_cell(spawn_cell),
		.spawn_exp(spawn_exp),
		.has_empty(has_empty)
	);

endmodule

// File: source/line_merge.sv
`timescale 1ns/100ps
`include "game_settings.svh"

module line_merge import game_pkg::*; (
	input line_t line_in,
	output line_t line_out,
	output score_t points,
	output logic changed
);

	localparam int N = `BOARD_N;
	localparam int EW = `EXP_W;

	// nonzero cells toward index 0, order kept.
	function automatic line_t pack_line(input line_t l);
		line_t r;
		int k;
		r = '0;
		k = 0;
		for (int i = 0; i < N; i++) begin
			if (l[EW*i +: EW] != '0) begin
				r[EW*k +: EW] = l[EW*i +: EW];
				k++;
			end
		end
		return r;
	endfunction

	line_t packed_in;
	line_t merged;

	always_comb begin
		logic skip;
		exp_t e;
		packed_in = pack_line(line_in);
		merged = packed_in;
		points = '0;
		skip = 1'b0;
		e = '0;
		for (int i = 0; i < N - 1; i++) begin
			if (skip) begin
				skip = 1'b0; // second half of a pair.
			end else if (packed_in[EW*i +: EW] != '0 &&
					packed_in[EW*i +: EW] == packed_in[EW*(i+1) +: EW]) begin
				e = packed_in[EW*i +: EW] + 1'b1;
				merged[EW*i +: EW] = e;
				merged[EW*(i+1) +: EW] = '0;
				points = points + (score_t'(1) << e);
				skip = 1'b1;
			end
		end
		line_out = pack_line(merged); // close the gaps.
		changed = (line_out != line_in);
	end

endmodule

// File: source/tile_spawner.sv
`timescale 1ns/100ps
`include "game_settings.svh"

module tile_spawner import game_pkg::*; (
	input logic clk,
	input logic rst_n,
	input board_t cur_board,
	input logic spawn_step,
	output cell_idx_t spawn_cell,
	output exp_t spawn_exp,
	output logic has_empty
);

	localparam int CELLS = `BOARD_N * `BOARD_N;
	localparam int EW = `EXP_W;

	logic [15:0] lfsr;

	// galois lfsr, shifts right.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= `LFSR_SEED;
		end else if (spawn_step) begin
			lfsr <= (lfsr >> 1) ^ (lfsr[0] ? `LFSR_TAPS : 16'h0000);
		end
	end

	// first empty cell from lfsr[3:0] upward, wrapping.
	always_comb begin
		cell_idx_t idx;
		has_empty = 1'b0;
		spawn_cell = '0;
		idx = '0;
		for (int off = 0; off < CELLS; off++) begin
			idx = cell_idx_t'(lfsr[3:0] + off);
			if (!has_empty && cur_board[EW*idx +: EW] == '0) begin
				has_empty = 1'b1;
				spawn_cell = idx;
			end
		end
	end

	// a 4 now and then, mostly 2s.
	assign spawn_exp = (lfsr[7:4] == 4'h0) ? exp_t'(2) : exp_t'(1);

endmodule
